// File: design/axis_merge_defs.svh
////////////////////////////////////////////////////////////////////////////
// Sizing constants for the two-port stream merger, included by the package
// and by every module that needs a width, a port count or the stall limit
////////////////////////////////////////////////////////////////////////////

`ifndef AXIS_MERGE_DEFS_SVH
`define AXIS_MERGE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Stream geometry
////////////////////////////////////////////////////////////////////////////

// Bytes carried by one beat, which also sets the keep mask width
`define AXIS_DATA_BYTES 4

// Number of peer source streams feeding the arbiter
`define AXIS_NUM_PORTS 2

////////////////////////////////////////////////////////////////////////////
// Monitor limits
////////////////////////////////////////////////////////////////////////////

// Longest legal run of cycles with output valid high and ready low
// A longer stall sets the sticky protocol error
`define AXIS_MAX_STALL 64

// Width of the per-packet byte counter in the monitor
`define AXIS_COUNT_BITS 16

`endif

// File: design/axis_merge_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the merger: width typedefs, beat structs, arbiter states
////////////////////////////////////////////////////////////////////////////

`include "axis_merge_defs.svh"

package axis_merge_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [`AXIS_DATA_BYTES*8-1:0] axis_data_t;
	typedef logic [`AXIS_DATA_BYTES-1:0] axis_keep_t;
	typedef logic [1:0] axis_dest_t;

	// One bit is enough to name either of the two source ports
	typedef logic [$clog2(`AXIS_NUM_PORTS)-1:0] port_id_t;

	typedef logic [`AXIS_COUNT_BITS-1:0] byte_count_t;

	////////////////////////////////////////////////////////////////////////////
	// Beat payloads
	////////////////////////////////////////////////////////////////////////////

	// A keep-only beat with no strobe field
	typedef struct packed {
		axis_data_t data;
		axis_keep_t keep;
		logic last;
		axis_dest_t dest;
		logic user;
	} axis_beat_t;

	// The merged output beat carries the port it came from
	typedef struct packed {
		axis_beat_t beat;
		port_id_t src;
	} axis_tagged_beat_t;

	// Arbiter is either free to grant or locked onto one packet
	typedef enum logic {ARB_IDLE, ARB_PACKET} arb_state_t;

endpackage

// File: design/axis_skid_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Two-entry stream buffer with a registered ready, one per input port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module axis_skid_buffer
(
	input	logic				i_aclk,
	input	logic				i_aresetn,
	input	logic				i_valid,
	input	axis_merge_pkg::axis_beat_t	i_beat,
	output	logic				o_ready,
	output	logic				o_valid,
	input	logic				i_ready,
	output	axis_merge_pkg::axis_beat_t	o_beat
);
	import axis_merge_pkg::*;

	// Number of beats held, from 0 to 2
	logic [1:0] count;
	logic [1:0] count_nxt;

	// Slot 0 is always the head that drives the output
	axis_beat_t slot0;
	axis_beat_t slot1;

	logic wr;
	logic rd;

	assign wr = i_valid && o_ready;
	assign rd = o_valid && i_ready;

	assign o_valid = (count != 2'd0);
	assign o_beat = slot0;

	always_comb
	begin
		case ({wr, rd})
			2'b10: count_nxt = count + 2'd1;
			2'b01: count_nxt = count - 2'd1;
			default: count_nxt = count;
		endcase
	end

	// Ready is computed from the next count so it closes as soon as
	// the second slot fills, without looking at downstream ready
	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			count <= 2'd0;
			o_ready <= 1'b0;
		end
		else
		begin
			count <= count_nxt;
			o_ready <= (count_nxt != 2'd2);
		end
	end

	always_ff @(posedge i_aclk)
	begin
		if (rd)
		begin
			// The head leaves and the next beat in order moves up
			if (count == 2'd2)
				slot0 <= slot1;
			else if (wr)
				slot0 <= i_beat;
		end
		else if (wr)
		begin
			if (count == 2'd0)
				slot0 <= i_beat;
			else
				slot1 <= i_beat;
		end
	end

	// The ready registered one cycle earlier must already block a write
	assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		(count == 2'd2) |-> !wr);

endmodule

// File: design/axis_packet_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin packet arbiter that merges the port streams into one output
// register and tags every beat with the port it came from
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "axis_merge_defs.svh"

module axis_packet_arbiter
(
	input	logic					i_aclk,
	input	logic					i_aresetn,
	input	logic [`AXIS_NUM_PORTS-1:0]		i_req_valid,
	input	axis_merge_pkg::axis_beat_t		i_req_beat [`AXIS_NUM_PORTS],
	output	logic [`AXIS_NUM_PORTS-1:0]		o_req_ready,
	output	logic					o_m_valid,
	input	logic					i_m_ready,
	output	axis_merge_pkg::axis_tagged_beat_t	o_m_beat
);
	import axis_merge_pkg::*;

	arb_state_t state;

	// Granted port, which also serves as the last winner for round-robin
	port_id_t grant;

	// Round-robin search result
	port_id_t pick;
	logic pick_found;
	int cand;

	// Port being served this cycle and its current beat
	port_id_t sel;
	axis_beat_t sel_beat;

	logic out_free;
	logic take;
	logic take_last;

	////////////////////////////////////////////////////////////////////////////
	// Grant selection
	////////////////////////////////////////////////////////////////////////////

	// Search starts one port after the last winner and wraps around
	always_comb
	begin
		pick = grant;
		pick_found = 1'b0;
		cand = 0;
		for (int i = 1; i <= `AXIS_NUM_PORTS; i++)
		begin
			cand = (int'(grant) + i) % `AXIS_NUM_PORTS;
			if (!pick_found && i_req_valid[cand])
			begin
				pick = port_id_t'(cand);
				pick_found = 1'b1;
			end
		end
	end

	// In idle the new pick is served at once, which saves a cycle of latency
	assign sel = (state == ARB_IDLE) ? pick : grant;
	assign sel_beat = i_req_beat[sel];

	// The output register can load when empty or when it drains this cycle
	assign out_free = !o_m_valid || i_m_ready;
	assign take = out_free && i_req_valid[sel];
	assign take_last = take && sel_beat.last;

	always_comb
	begin
		o_req_ready = '0;
		if (out_free)
			o_req_ready[sel] = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Packet FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			state <= ARB_IDLE;
			// Port 0 wins the first search after reset
			grant <= port_id_t'(`AXIS_NUM_PORTS - 1);
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					if (pick_found)
					begin
						grant <= pick;
						// A single-beat packet never leaves idle
						if (!take_last)
							state <= ARB_PACKET;
					end
				end
				ARB_PACKET:
				begin
					if (take_last)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
			o_m_valid <= 1'b0;
		else if (out_free)
			o_m_valid <= take;
	end

	always_ff @(posedge i_aclk)
	begin
		if (take)
		begin
			o_m_beat.beat <= sel_beat;
			o_m_beat.src <= sel;
		end
	end

	// Only one skid buffer may drain into the output at a time
	assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		$onehot0(o_req_ready));

	// Once locked the grant holds until the packet is finished
	assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		(state == ARB_PACKET) |=> $stable(grant));

endmodule

// File: design/axis_stream_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Passive monitor on the merged stream that reports packet byte counts and
// keeps a sticky flag for handshake rule violations
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "axis_merge_defs.svh"

module axis_stream_monitor
(
	input	logic					i_aclk,
	input	logic					i_aresetn,
	input	logic					i_valid,
	input	logic					i_ready,
	input	axis_merge_pkg::axis_tagged_beat_t	i_beat,
	output	logic					o_pkt_valid,
	output	axis_merge_pkg::byte_count_t		o_pkt_bytes,
	output	axis_merge_pkg::axis_dest_t		o_pkt_dest,
	output	logic					o_proto_err
);
	import axis_merge_pkg::*;

	// Wide enough to reach one past the limit before saturating
	localparam int STALL_BITS = $clog2(`AXIS_MAX_STALL + 2);

	logic handshake;
	logic stalled;

	byte_count_t beat_bytes;
	byte_count_t run_bytes;

	logic [STALL_BITS-1:0] stall_cnt;
	logic stall_q;
	axis_tagged_beat_t beat_q;

	logic err_change;
	logic err_drop;
	logic err_long;

	assign handshake = i_valid && i_ready;
	assign stalled = i_valid && !i_ready;

	////////////////////////////////////////////////////////////////////////////
	// Packet byte counting
	////////////////////////////////////////////////////////////////////////////

	// Each set keep bit marks one valid byte in the beat
	always_comb
	begin
		beat_bytes = '0;
		for (int k = 0; k < `AXIS_DATA_BYTES; k++)
		begin
			if (i_beat.beat.keep[k])
				beat_bytes = beat_bytes + byte_count_t'(1);
		end
	end

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			run_bytes <= '0;
			o_pkt_valid <= 1'b0;
		end
		else
		begin
			o_pkt_valid <= handshake && i_beat.beat.last;
			if (handshake)
				run_bytes <= i_beat.beat.last ? '0 : (run_bytes + beat_bytes);
		end
	end

	// The report includes the bytes of the closing beat itself
	always_ff @(posedge i_aclk)
	begin
		if (handshake && i_beat.beat.last)
		begin
			o_pkt_bytes <= run_bytes + beat_bytes;
			o_pkt_dest <= i_beat.beat.dest;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stall tracking and protocol errors
	////////////////////////////////////////////////////////////////////////////

	// Counts the stalled cycles seen before the current one
	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn || !stalled)
			stall_cnt <= '0;
		else if (!(&stall_cnt))
			stall_cnt <= stall_cnt + 1'b1;
	end

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
			stall_q <= 1'b0;
		else
			stall_q <= stalled;
	end

	always_ff @(posedge i_aclk)
	begin
		if (stalled)
			beat_q <= i_beat;
	end

	// After a stalled cycle the same beat must still be offered
	assign err_change = stall_q && i_valid && (i_beat != beat_q);
	assign err_drop = stall_q && !i_valid;
	assign err_long = stalled && (stall_cnt >= STALL_BITS'(`AXIS_MAX_STALL));

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
			o_proto_err <= 1'b0;
		else if (err_change || err_drop || err_long)
			o_proto_err <= 1'b1;
	end

	// Same rule as the change and drop flags, checked in simulation
	assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		stalled |=> (i_valid && $stable(i_beat)));

endmodule

// File: design/axis_merge_top.sv
////////////////////////////////////////////////////////////////////////////
// Two-port packet merger top with input skid buffers, arbiter and monitor
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "axis_merge_defs.svh"

module axis_merge_top
(
	input	logic					i_aclk,
	input	logic					i_aresetn,
	input	logic					i_s0_valid,
	input	axis_merge_pkg::axis_beat_t		i_s0_beat,
	output	logic					o_s0_ready,
	input	logic					i_s1_valid,
	input	axis_merge_pkg::axis_beat_t		i_s1_beat,
	output	logic					o_s1_ready,
	output	logic					o_m_valid,
	input	logic					i_m_ready,
	output	axis_merge_pkg::axis_tagged_beat_t	o_m_beat,
	output	logic					o_pkt_valid,
	output	axis_merge_pkg::byte_count_t		o_pkt_bytes,
	output	axis_merge_pkg::axis_dest_t		o_pkt_dest,
	output	logic					o_proto_err
);
	import axis_merge_pkg::*;

	// Streams from the skid buffers into the arbiter, indexed by port
	logic [`AXIS_NUM_PORTS-1:0] req_valid;
	logic [`AXIS_NUM_PORTS-1:0] req_ready;
	axis_beat_t req_beat [`AXIS_NUM_PORTS];

	axis_skid_buffer skid_0 (
		.i_aclk		(i_aclk),
		.i_aresetn	(i_aresetn),
		.i_valid	(i_s0_valid),
		.i_beat		(i_s0_beat),
		.o_ready	(o_s0_ready),
		.o_valid	(req_valid[0]),
		.i_ready	(req_ready[0]),
		.o_beat		(req_beat[0])
	);

	axis_skid_buffer skid_1 (
		.i_aclk		(i_aclk),
		.i_aresetn	(i_aresetn),
		.i_valid	(i_s1_valid),
		.i_beat		(i_s1_beat),
		.o_ready	(o_s1_ready),
		.o_valid	(req_valid[1]),
		.i_ready	(req_ready[1]),
		.o_beat		(req_beat[1])
	);

	axis_packet_arbiter arbiter (
		.i_aclk		(i_aclk),
		.i_aresetn	(i_aresetn),
		.i_req_valid	(req_valid),
		.i_req_beat	(req_beat),
		.o_req_ready	(req_ready),
		.o_m_valid	(o_m_valid),
		.i_m_ready	(i_m_ready),
		.o_m_beat	(o_m_beat)
	);

	// Watches the shared output only and never drives the stream
	axis_stream_monitor monitor (
		.i_aclk		(i_aclk),
		.i_aresetn	(i_aresetn),
		.i_valid	(o_m_valid),
		.i_ready	(i_m_ready),
		.i_beat		(o_m_beat),
		.o_pkt_valid	(o_pkt_valid),
		.o_pkt_bytes	(o_pkt_bytes),
		.o_pkt_dest	(o_pkt_dest),
		.o_proto_err	(o_proto_err)
	);

endmodule

// File: bench/axis_merge_tb.sv
////////////////////////////////////////////////////////////////////////////
// Table-driven testbench for the two-port merger, run as the simulation top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "axis_merge_defs.svh"

module axis_merge_tb;
	import axis_merge_pkg::*;

	// One table row is one packet, phase 1 rows form the fairness test
	typedef struct packed {
		logic phase;
		port_id_t port;
		logic [7:0] len;
		axis_dest_t dest;
		axis_keep_t last_keep;
		axis_data_t data_base;
		logic [7:0] stall_pct;
	} row_t;

	typedef struct packed {
		logic [7:0] row;
		axis_beat_t beat;
	} exp_beat_t;

	typedef struct packed {
		logic [7:0] row;
		byte_count_t bytes;
		axis_dest_t dest;
	} exp_pkt_t;

	localparam int NUM_ROWS = 16;

	// Columns: phase, port, beats, dest, last keep, data base, ready stall percent
	localparam row_t ROWS [NUM_ROWS] = '{
		'{0, 0, 3, 1, 4'b1111, 32'h1000_0000, 0},
		'{0, 1, 1, 2, 4'b0001, 32'h2000_0000, 0},
		'{0, 0, 5, 0, 4'b0011, 32'h1100_0000, 30},
		'{0, 1, 4, 3, 4'b0111, 32'h2100_0000, 30},
		'{0, 1, 2, 1, 4'b1111, 32'h2200_0000, 50},
		'{0, 0, 1, 2, 4'b0111, 32'h1200_0000, 50},
		'{0, 0, 6, 3, 4'b0001, 32'h1300_0000, 60},
		'{0, 1, 6, 0, 4'b0011, 32'h2300_0000, 60},
		'{0, 0, 2, 1, 4'b1111, 32'h1400_0000, 20},
		'{0, 1, 3, 2, 4'b0001, 32'h2400_0000, 20},
		'{1, 0, 2, 0, 4'b1111, 32'h3000_0000, 25},
		'{1, 1, 3, 1, 4'b0011, 32'h4000_0000, 25},
		'{1, 0, 4, 2, 4'b0111, 32'h3100_0000, 25},
		'{1, 1, 2, 3, 4'b0001, 32'h4100_0000, 25},
		'{1, 0, 3, 1, 4'b0011, 32'h3200_0000, 25},
		'{1, 1, 2, 2, 4'b1111, 32'h4200_0000, 25}
	};

	logic i_aclk = 1'b0;
	logic i_aresetn;
	logic [`AXIS_NUM_PORTS-1:0] s_valid;
	logic [`AXIS_NUM_PORTS-1:0] s_ready;
	axis_beat_t s_beat [`AXIS_NUM_PORTS];
	logic i_m_ready;
	logic o_m_valid;
	axis_tagged_beat_t o_m_beat;
	logic o_pkt_valid;
	byte_count_t o_pkt_bytes;
	axis_dest_t o_pkt_dest;
	logic o_proto_err;

	// Rows waiting for a driver, and what the output owes each port
	row_t port_rows [`AXIS_NUM_PORTS][$];
	exp_beat_t exp_beats [`AXIS_NUM_PORTS][$];
	exp_pkt_t exp_pkts [`AXIS_NUM_PORTS][$];

	logic rst_done = 1'b0;
	logic hold_ready = 1'b0;
	logic fair_phase = 1'b0;
	logic have_prev = 1'b0;
	logic in_pkt = 1'b0;
	logic proto_seen = 1'b0;
	port_id_t prev_src;
	port_id_t cur_src;
	port_id_t rep_src;
	int cur_stall = 0;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;

	axis_merge_top dut (
		.i_aclk		(i_aclk),
		.i_aresetn	(i_aresetn),
		.i_s0_valid	(s_valid[0]),
		.i_s0_beat	(s_beat[0]),
		.o_s0_ready	(s_ready[0]),
		.i_s1_valid	(s_valid[1]),
		.i_s1_beat	(s_beat[1]),
		.o_s1_ready	(s_ready[1]),
		.o_m_valid	(o_m_valid),
		.i_m_ready	(i_m_ready),
		.o_m_beat	(o_m_beat),
		.o_pkt_valid	(o_pkt_valid),
		.o_pkt_bytes	(o_pkt_bytes),
		.o_pkt_dest	(o_pkt_dest),
		.o_proto_err	(o_proto_err)
	);

	always #20 i_aclk = ~i_aclk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			value_errors++;
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Body beats carry every byte, only the closing beat uses the row mask
	function automatic axis_beat_t make_beat(input row_t r, input int k);
		axis_beat_t b;
		b.data = r.data_base + axis_data_t'(k);
		b.last = (k == int'(r.len) - 1);
		b.keep = b.last ? r.last_keep : '1;
		b.dest = r.dest;
		b.user = k[0];
		return b;
	endfunction

	function automatic int total_beats();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ROWS; i++)
			n += int'(ROWS[i].len);
		return n;
	endfunction

	task automatic queue_row(input int i);
		row_t r;
		exp_beat_t eb;
		exp_pkt_t ep;
		r = ROWS[i];
		port_rows[r.port].push_back(r);
		for (int k = 0; k < int'(r.len); k++)
		begin
			eb.row = 8'(i);
			eb.beat = make_beat(r, k);
			exp_beats[r.port].push_back(eb);
		end
		ep.row = 8'(i);
		ep.bytes = byte_count_t'((int'(r.len) - 1) * `AXIS_DATA_BYTES + $countones(r.last_keep));
		ep.dest = r.dest;
		exp_pkts[r.port].push_back(ep);
	endtask

	// Ready is registered in the skid buffer, so it is read at the falling edge
	task automatic wait_accept(input int p);
		logic acc;
		acc = 1'b0;
		while (!acc)
		begin
			@(negedge i_aclk);
			acc = s_ready[p];
			@(posedge i_aclk);
			#2;
		end
	endtask

	task automatic drive_port(input int p);
		row_t r;
		int gap;
		wait (rst_done);
		@(posedge i_aclk);
		#2;
		forever
		begin
			if (port_rows[p].size() == 0)
			begin
				@(posedge i_aclk);
				#2;
			end
			else
			begin
				r = port_rows[p].pop_front();
				cur_stall = int'(r.stall_pct);
				for (int k = 0; k < int'(r.len); k++)
				begin
					s_valid[p] = 1'b1;
					s_beat[p] = make_beat(r, k);
					wait_accept(p);
				end
				s_valid[p] = 1'b0;
				// Idle gaps only in the random phase, fairness needs full buffers
				gap = (r.phase == 1'b0) ? int'($urandom % 3) : 0;
				repeat (gap)
				begin
					@(posedge i_aclk);
					#2;
				end
			end
		end
	endtask

	initial drive_port(0);
	initial drive_port(1);

	// Output ready, random per cycle or held low to let both ports queue up
	always @(posedge i_aclk)
	begin
		#2;
		if (!rst_done || hold_ready)
			i_m_ready = 1'b0;
		else
			i_m_ready = (int'($urandom % 100) >= cur_stall);
	end

	////////////////////////////////////////////////////////////////////////////
	// Output checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_report();
		exp_pkt_t e;
		if (exp_pkts[rep_src].size() == 0)
		begin
			other_errors++;
			$display("Packet report from port %0d with no packet outstanding", rep_src);
		end
		else
		begin
			e = exp_pkts[rep_src].pop_front();
			check_value($sformatf("row%0d pkt_bytes", e.row), e.bytes, o_pkt_bytes);
			check_value($sformatf("row%0d pkt_dest", e.row), e.dest, o_pkt_dest);
		end
	endtask

	task automatic check_beat(input axis_tagged_beat_t t);
		exp_beat_t e;
		if (in_pkt)
			check_value("no interleave src", cur_src, t.src);
		in_pkt = !t.beat.last;
		cur_src = t.src;
		if (exp_beats[t.src].size() == 0)
		begin
			other_errors++;
			$display("Output beat from port %0d that was never sent", t.src);
		end
		else
		begin
			e = exp_beats[t.src].pop_front();
			check_value($sformatf("row%0d beat", e.row), e.beat, t.beat);
		end
		if (t.beat.last)
		begin
			// Both ports still owe packets, so the grant must have switched
			if (fair_phase && have_prev && exp_pkts[0].size() > 0 && exp_pkts[1].size() > 0)
				check_value("fairness src",
					port_id_t'((int'(prev_src) + 1) % `AXIS_NUM_PORTS), t.src);
			prev_src = t.src;
			have_prev = 1'b1;
			rep_src = t.src;
		end
	endtask

	// The report of a packet is taken before the beat of the same cycle
	always @(negedge i_aclk)
	begin
		if (rst_done)
		begin
			if (o_pkt_valid)
				check_report();
			if (o_m_valid && i_m_ready)
				check_beat(o_m_beat);
			if (o_proto_err && !proto_seen)
			begin
				proto_seen = 1'b1;
				other_errors++;
				$display("Protocol error flag went high at %0t", $time);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : watchdog
		int limit;
		limit = total_beats() * 20 + 200;
		repeat (limit) @(posedge i_aclk);
		$display("Timeout after %0d cycles, the merged stream never drained", limit);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		void'($urandom(80));
		i_aresetn = 1'b0;
		i_m_ready = 1'b0;
		s_valid = '0;
		for (int p = 0; p < `AXIS_NUM_PORTS; p++)
			s_beat[p] = '0;
		repeat (15) @(posedge i_aclk);
		@(negedge i_aclk);
		check_value("reset s_ready", 2'b00, s_ready);
		@(posedge i_aclk);
		#2;
		i_aresetn = 1'b1;
		@(negedge i_aclk);
		check_value("after reset m_valid", 1'b0, o_m_valid);
		check_value("after reset pkt_valid", 1'b0, o_pkt_valid);
		check_value("after reset proto_err", 1'b0, o_proto_err);
		@(negedge i_aclk);
		check_value("after reset s_ready", 2'b11, s_ready);
		rst_done = 1'b1;
		for (int ph = 0; ph < 2; ph++)
		begin
			fair_phase = (ph == 1);
			have_prev = 1'b0;
			hold_ready = fair_phase;
			for (int i = 0; i < NUM_ROWS; i++)
				if (int'(ROWS[i].phase) == ph)
					queue_row(i);
			// Release the output once both skid buffers hold data
			while (hold_ready && dut.req_valid != 2'b11)
				@(negedge i_aclk);
			hold_ready = 1'b0;
			while (exp_beats[0].size() + exp_beats[1].size() +
				exp_pkts[0].size() + exp_pkts[1].size() != 0)
				@(negedge i_aclk);
			// Extra cycles would expose a duplicated beat or report
			repeat (8) @(negedge i_aclk);
		end
		check_value("end proto_err", 1'b0, o_proto_err);
		$display("Checks %0d, value mismatches %0d, other errors %0d",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: axis_merge_top.f
+incdir+design
design/axis_merge_pkg.sv
design/axis_skid_buffer.sv
design/axis_packet_arbiter.sv
design/axis_stream_monitor.sv
design/axis_merge_top.sv
bench/axis_merge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the two-port stream merger bench with Verilator and runs it.
# The run counts as failed when the log holds the fail message or lacks the pass message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
	-f axis_merge_top.f \
	--top-module axis_merge_tb \
	-o axis_merge_sim \
	> build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

obj_dir/axis_merge_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
